/* include/pet_macros.svh */
// PET loader constants
// Memory map, zero-page pointers, download index codes and divider terms

`ifndef PET_MACROS_SVH
`define PET_MACROS_SVH

////////////////////
// Memory map
////////////////////

// Exclusive top of PRG data and of the ROM window
`define PET_PRG_LIMIT     16'h8000

// First ROM image offset that is copied
`define PET_ROM_BASE      16'h0400

// Added to a ROM image offset to form the PET address
`define PET_ROM_OFFSET    16'h8000

// Zero-page end-of-program pointer
`define PET_PTR_LO        16'h002A
`define PET_PTR_HI        16'h002B

////////////////////
// Download index codes
////////////////////

`define PET_IDX_ROM_A     8'h00
`define PET_IDX_ROM_B     8'h02
`define PET_IDX_PRG       8'h41

////////////////////
// Clocking and reset
////////////////////

// Video phase counter width, one video pixel per 8 system clocks
`define PET_CE7_DIV_BITS  3

// Last count of the reset settle counter
`define PET_RESET_SETTLE  4'd14

// CPU divider terms, enable period is term + 1
`define PET_RATE_NORMAL   7'd55
`define PET_RATE_FAST     7'd45
`define PET_RATE_TURBO    7'd34
`define PET_RATE_TURBOP   7'd24

`endif

/* design/pet_dl_pkg.sv */
// Download package
// Address, byte and download kind types shared by the loader blocks

package pet_dl_pkg;

	////////////////////
	// Data types
	////////////////////

	// Address on the PET side of the DMA port
	typedef logic [15:0] pet_addr_t;

	// One download or memory byte
	typedef logic [7:0] pet_byte_t;

	////////////////////
	// Download kind
	////////////////////

	// What the active download is used for
	typedef enum logic [1:0] {
		// No download, or an index the core ignores
		DL_NONE = 2'd0,
		// ROM image, copied into the upper half of memory
		DL_ROM  = 2'd1,
		// Program file with a two-byte load address in front
		DL_PRG  = 2'd2
	} dl_kind_t;

endpackage

/* design/pet_clk_pkg.sv */
// Clock enable package
// CPU speed selection and divider count types

package pet_clk_pkg;

	////////////////////
	// CPU speed
	////////////////////

	// Selected CPU clock rate, slowest first
	typedef enum logic [1:0] {
		SPD_NORMAL = 2'd0,
		SPD_FAST   = 2'd1,
		SPD_TURBO  = 2'd2,
		SPD_TURBOP = 2'd3
	} cpu_speed_t;

	////////////////////
	// Divider
	////////////////////

	// Count of the CPU enable divider, wide enough for the slowest term
	typedef logic [6:0] cpu_div_t;

endpackage

/* design/pet_clk_enables.sv */
// Clock enable generator
// Video phase enables from a divide-by-8 counter and a CPU enable
// with four selectable divisor terms

`include "pet_macros.svh"

module pet_clk_enables (
	input  logic                   clk_sys,
	input  logic                   initRESET,
	input  pet_clk_pkg::cpu_speed_t cpu_speed_i,
	output logic                   ce_7mp_o,
	output logic                   ce_7mn_o,
	output logic                   ce_1m_o
);

	import pet_clk_pkg::*;

	logic [`PET_CE7_DIV_BITS-1:0] phase;
	cpu_div_t                     cpu_div;
	cpu_div_t                     cpu_rate;
	cpu_div_t                     rate_sel;

	////////////////////
	// Video phase
	////////////////////

	// Positive phase at count zero, negative phase half a period later
	always_ff @(posedge clk_sys) begin
		if (initRESET) begin
			phase    <= '0;
			ce_7mp_o <= 1'b0;
			ce_7mn_o <= 1'b0;
		end else begin
			phase    <= phase + 1'b1;
			ce_7mp_o <= (phase == '0);
			ce_7mn_o <= (phase == {1'b1, {(`PET_CE7_DIV_BITS-1){1'b0}}});
		end
	end

	////////////////////
	// CPU enable
	////////////////////

	// Divisor term for the selected speed
	always_comb begin
		unique case (cpu_speed_i)
			SPD_NORMAL: rate_sel = `PET_RATE_NORMAL;
			SPD_FAST:   rate_sel = `PET_RATE_FAST;
			SPD_TURBO:  rate_sel = `PET_RATE_TURBO;
			default:    rate_sel = `PET_RATE_TURBOP;
		endcase
	end

	// New speed only picked up at the wrap
	always_ff @(posedge clk_sys) begin
		if (initRESET) begin
			cpu_div  <= '0;
			cpu_rate <= `PET_RATE_NORMAL;
			ce_1m_o  <= 1'b0;
		end else begin
			if (cpu_div == cpu_rate) begin
				cpu_div  <= '0;
				cpu_rate <= rate_sel;
			end else begin
				cpu_div <= cpu_div + 1'b1;
			end
			ce_1m_o <= (cpu_div == '0);
		end
	end

	// Video phases are half a period apart
	a_phase_excl: assert property (@(posedge clk_sys) disable iff (initRESET)
		!(ce_7mp_o && ce_7mn_o));

endmodule

/* design/pet_reset_seq.sv */
// Core reset sequencer
// Holds the core in reset until a settle count has run out,
// and for the whole of a ROM download

`include "pet_macros.svh"

module pet_reset_seq (
	input  logic clk_sys,
	input  logic initRESET,
	input  logic reset_req_i,
	input  logic rom_active,
	output logic core_reset_o
);

	logic [3:0] settle_cnt;
	logic       hold;

	// Restart on any reset source, release one cycle after the last count
	always_ff @(posedge clk_sys) begin
		if (initRESET || reset_req_i) begin
			settle_cnt <= '0;
			hold       <= 1'b1;
		end else if (settle_cnt != `PET_RESET_SETTLE) begin
			settle_cnt <= settle_cnt + 1'b1;
			hold       <= 1'b1;
		end else begin
			hold <= 1'b0;
		end
	end

	// A new ROM must not be run while it is being written
	assign core_reset_o = hold | reset_req_i | rom_active;

endmodule

/* design/pet_load_fsm.sv */
// Download control FSM
// Classifies the host download by index and sequences the two
// end-of-program pointer writes after a PRG download

`include "pet_macros.svh"

module pet_load_fsm (
	input  logic                  clk_sys,
	input  logic                  initRESET,
	input  logic                  ioctl_download_i,
	input  pet_dl_pkg::pet_byte_t ioctl_index_i,
	output logic                  prg_active,
	output logic                  rom_active,
	output logic                  ptr_lo_stb,
	output logic                  ptr_hi_stb
);

	import pet_dl_pkg::*;

	// PTR_LO and PTR_HI are the cycles the pointer bytes sit on the DMA port
	typedef enum logic [2:0] {
		IDLE    = 3'd0,
		PRG_RX  = 3'd1,
		ROM_RX  = 3'd2,
		PTR_LO  = 3'd3,
		PTR_GAP = 3'd4,
		PTR_HI  = 3'd5
	} load_state_t;

	load_state_t state;
	load_state_t state_nxt;
	load_state_t entry;
	dl_kind_t    kind;

	////////////////////
	// Index decode
	////////////////////

	always_comb begin
		kind = DL_NONE;
		if (ioctl_download_i) begin
			if (ioctl_index_i == `PET_IDX_ROM_A || ioctl_index_i == `PET_IDX_ROM_B)
				kind = DL_ROM;
			else if (ioctl_index_i == `PET_IDX_PRG)
				kind = DL_PRG;
		end
	end

	// Receive state for a download that starts now
	assign entry = (kind == DL_PRG) ? PRG_RX :
	               (kind == DL_ROM) ? ROM_RX : IDLE;

	////////////////////
	// State machine
	////////////////////

	always_comb begin
		state_nxt = state;
		unique case (state)
			IDLE:    state_nxt = entry;
			PRG_RX:  if (!ioctl_download_i) state_nxt = PTR_LO;
			ROM_RX:  if (!ioctl_download_i) state_nxt = IDLE;
			// A fresh download drops the rest of the pointer sequence
			PTR_LO:  state_nxt = ioctl_download_i ? entry : PTR_GAP;
			PTR_GAP: state_nxt = ioctl_download_i ? entry : PTR_HI;
			PTR_HI:  state_nxt = entry;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (initRESET)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	// Decoded from the level so the first strobe of a download is caught
	assign prg_active = (kind == DL_PRG);
	assign rom_active = (kind == DL_ROM);

	// One cycle ahead of the write they request
	assign ptr_lo_stb = (state == PRG_RX) && !ioctl_download_i;
	assign ptr_hi_stb = (state == PTR_GAP) && !ioctl_download_i;

	a_ptr_idle: assert property (@(posedge clk_sys) disable iff (initRESET)
		(ptr_lo_stb || ptr_hi_stb) |-> !prg_active);

endmodule

/* design/pet_dma_writer.sv */
// DMA write path
// Holds the PRG load address, maps ROM image offsets into memory and
// drives the registered DMA write port

`include "pet_macros.svh"

module pet_dma_writer (
	input  logic                  clk_sys,
	input  logic                  initRESET,
	input  logic                  prg_active,
	input  logic                  rom_active,
	input  logic                  ptr_lo_stb,
	input  logic                  ptr_hi_stb,
	input  logic                  ioctl_wr_i,
	input  logic [24:0]           ioctl_addr_i,
	input  pet_dl_pkg::pet_byte_t ioctl_dout_i,
	output pet_dl_pkg::pet_addr_t dma_addr_o,
	output pet_dl_pkg::pet_byte_t dma_data_o,
	output logic                  dma_we_o
);

	import pet_dl_pkg::*;

	pet_addr_t load_addr;
	pet_addr_t addr_nxt;
	pet_byte_t data_nxt;
	logic      hdr_lo;
	logic      hdr_hi;
	logic      prg_wr;
	logic      rom_wr;
	logic      rom_window;
	logic      wr_any;

	////////////////////
	// Write decode
	////////////////////

	// First two PRG bytes carry the load address
	assign hdr_lo = prg_active && ioctl_wr_i && (ioctl_addr_i == 25'd0);
	assign hdr_hi = prg_active && ioctl_wr_i && (ioctl_addr_i == 25'd1);
	assign prg_wr = prg_active && ioctl_wr_i && (ioctl_addr_i > 25'd1)
	                && (load_addr < `PET_PRG_LIMIT);

	assign rom_window = (ioctl_addr_i >= 25'(`PET_ROM_BASE))
	                    && (ioctl_addr_i < 25'(`PET_PRG_LIMIT));
	assign rom_wr = rom_active && ioctl_wr_i && rom_window;

	assign wr_any = prg_wr | rom_wr | ptr_lo_stb | ptr_hi_stb;

	always_comb begin
		addr_nxt = load_addr;
		data_nxt = ioctl_dout_i;
		if (rom_wr) begin
			addr_nxt = ioctl_addr_i[15:0] + `PET_ROM_OFFSET;
		end else if (ptr_lo_stb) begin
			addr_nxt = `PET_PTR_LO;
			data_nxt = load_addr[7:0];
		end else if (ptr_hi_stb) begin
			addr_nxt = `PET_PTR_HI;
			data_nxt = load_addr[15:8];
		end
	end

	////////////////////
	// Registers
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (initRESET)
			dma_we_o <= 1'b0;
		else
			dma_we_o <= wr_any;
	end

	// Load address stops at the limit, which is the pointer value left behind
	always_ff @(posedge clk_sys) begin
		if (hdr_lo)
			load_addr[7:0] <= ioctl_dout_i;
		if (hdr_hi)
			load_addr[15:8] <= ioctl_dout_i;
		if (prg_wr)
			load_addr <= load_addr + 1'b1;
		if (wr_any) begin
			dma_addr_o <= addr_nxt;
			dma_data_o <= data_nxt;
		end
	end

	a_single_we: assert property (@(posedge clk_sys) disable iff (initRESET)
		ioctl_wr_i ##1 !(ioctl_wr_i || ptr_lo_stb || ptr_hi_stb) |=> !dma_we_o);

endmodule

/* design/pet_loader_top.sv */
// PET loader top level
// Clock enables, core reset and the host download to DMA path

module pet_loader_top (
	input  logic                    clk_sys,
	input  logic                    initRESET,
	input  logic                    reset_req_i,
	input  pet_clk_pkg::cpu_speed_t cpu_speed_i,
	input  logic                    ioctl_download_i,
	input  pet_dl_pkg::pet_byte_t   ioctl_index_i,
	input  logic                    ioctl_wr_i,
	input  logic [24:0]             ioctl_addr_i,
	input  pet_dl_pkg::pet_byte_t   ioctl_dout_i,
	output logic                    ce_7mp_o,
	output logic                    ce_7mn_o,
	output logic                    ce_1m_o,
	output logic                    core_reset_o,
	output pet_dl_pkg::pet_addr_t   dma_addr_o,
	output pet_dl_pkg::pet_byte_t   dma_data_o,
	output logic                    dma_we_o
);

	logic prg_active;
	logic rom_active;
	logic ptr_lo_stb;
	logic ptr_hi_stb;

	pet_clk_enables u_clk_enables (
		.clk_sys     (clk_sys),
		.initRESET   (initRESET),
		.cpu_speed_i (cpu_speed_i),
		.ce_7mp_o    (ce_7mp_o),
		.ce_7mn_o    (ce_7mn_o),
		.ce_1m_o     (ce_1m_o)
	);

	pet_reset_seq u_reset_seq (
		.clk_sys      (clk_sys),
		.initRESET    (initRESET),
		.reset_req_i  (reset_req_i),
		.rom_active   (rom_active),
		.core_reset_o (core_reset_o)
	);

	pet_load_fsm u_load_fsm (
		.clk_sys          (clk_sys),
		.initRESET        (initRESET),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.prg_active       (prg_active),
		.rom_active       (rom_active),
		.ptr_lo_stb       (ptr_lo_stb),
		.ptr_hi_stb       (ptr_hi_stb)
	);

	pet_dma_writer u_dma_writer (
		.clk_sys      (clk_sys),
		.initRESET    (initRESET),
		.prg_active   (prg_active),
		.rom_active   (rom_active),
		.ptr_lo_stb   (ptr_lo_stb),
		.ptr_hi_stb   (ptr_hi_stb),
		.ioctl_wr_i   (ioctl_wr_i),
		.ioctl_addr_i (ioctl_addr_i),
		.ioctl_dout_i (ioctl_dout_i),
		.dma_addr_o   (dma_addr_o),
		.dma_data_o   (dma_data_o),
		.dma_we_o     (dma_we_o)
	);

endmodule

/* dv/tb_pet_loader.sv */
// PET loader testbench
// Runs clock enables, core reset and host downloads through the loader,
// with concurrent assertions checking each output against the expected values

`include "pet_macros.svh"

module tb_pet_loader;

	import pet_dl_pkg::*;
	import pet_clk_pkg::*;

	localparam int          CLK_HALF     = 2;
	localparam int          RESET_CYCLES = 16;
	localparam int unsigned RAND_SEED    = 32'h53d8_91ca;
	// Six CPU enable periods per speed at the slowest rate, plus downloads and reset
	localparam int          TIMEOUT_CYCLES = 4 * 6 * (`PET_RATE_NORMAL + 1) + 600;
	localparam logic [24:0] ROM_OFFS [7] = '{25'h0000, 25'h03FF, 25'h0400, 25'h0401,
	                                         25'h1234, 25'h7FFF, 25'h8000};

	logic        clk_sys;
	logic        initRESET;
	logic        reset_req_i;
	cpu_speed_t  cpu_speed_i;
	logic        ioctl_download_i;
	pet_byte_t   ioctl_index_i;
	logic        ioctl_wr_i;
	logic [24:0] ioctl_addr_i;
	pet_byte_t   ioctl_dout_i;
	logic        ce_7mp_o;
	logic        ce_7mn_o;
	logic        ce_1m_o;
	logic        core_reset_o;
	pet_addr_t   dma_addr_o;
	pet_byte_t   dma_data_o;
	logic        dma_we_o;

	// Expected DMA port in this cycle and in the next one
	logic        exp_we;
	logic        nxt_we;
	pet_addr_t   exp_addr;
	pet_addr_t   nxt_addr;
	pet_byte_t   exp_data;
	pet_byte_t   nxt_data;
	pet_addr_t   ref_load;
	logic        prg_open;
	int          hi_wait;
	logic [5:0]  gap_7mp;
	logic [7:0]  gap_1m;
	logic [4:0]  quiet;
	logic        rate_armed;
	int          exp_1m_gap;
	logic        exp_core_reset;
	int          clk_errors;
	int          reset_errors;
	int          dma_errors;
	int          cycle_cnt;

	pet_loader_top UUT (
		.clk_sys          (clk_sys),
		.initRESET        (initRESET),
		.reset_req_i      (reset_req_i),
		.cpu_speed_i      (cpu_speed_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ce_7mp_o         (ce_7mp_o),
		.ce_7mn_o         (ce_7mn_o),
		.ce_1m_o          (ce_1m_o),
		.core_reset_o     (core_reset_o),
		.dma_addr_o       (dma_addr_o),
		.dma_data_o       (dma_data_o),
		.dma_we_o         (dma_we_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	////////////////////
	// Reference counters
	////////////////////

	// Cycles since the last enable pulse and since the last reset input
	// Video gap stays at zero until the first ce_7mp_o pulse
	always_ff @(posedge clk_sys) begin
		if (initRESET) begin
			gap_7mp <= '0;
			gap_1m  <= '0;
		end else begin
			gap_7mp <= ce_7mp_o ? 6'd1 : gap_7mp + (gap_7mp != '0 && gap_7mp != '1);
			gap_1m  <= ce_1m_o ? 8'd1 : gap_1m + (gap_1m != '1);
		end
		if (initRESET || reset_req_i)
			quiet <= '0;
		else if (quiet != '1)
			quiet <= quiet + 1'b1;
	end

	// Release 15 cycles after the last reset input, held during a ROM download
	assign exp_core_reset = reset_req_i || (quiet < 5'd15) || (ioctl_download_i
		&& (ioctl_index_i == `PET_IDX_ROM_A || ioctl_index_i == `PET_IDX_ROM_B));

	////////////////////
	// Assertions
	////////////////////

	a_7mp_period: assert property (@(posedge clk_sys) disable iff (initRESET)
		(gap_7mp != '0) |-> (ce_7mp_o == (gap_7mp == 6'd8)))
		else begin
			clk_errors++;
			$display("error at %0t: ce_7mp_o period is not 8 cycles", $time);
		end
	a_7mn_phase: assert property (@(posedge clk_sys) disable iff (initRESET)
		(gap_7mp != '0) |-> (ce_7mn_o == (gap_7mp == 6'd4)))
		else begin
			clk_errors++;
			$display("error at %0t: ce_7mn_o is not 4 cycles after ce_7mp_o", $time);
		end
	a_1m_period: assert property (@(posedge clk_sys) disable iff (initRESET)
		(ce_1m_o && rate_armed) |-> (gap_1m == exp_1m_gap))
		else begin
			clk_errors++;
			$display("error at %0t: ce_1m_o period, expected %0d", $time, exp_1m_gap);
		end
	a_reset_quiet: assert property (@(posedge clk_sys)
		initRESET |=> !(ce_7mp_o || ce_7mn_o || ce_1m_o || dma_we_o))
		else begin
			reset_errors++;
			$display("error at %0t: outputs not low after reset", $time);
		end
	a_core_reset: assert property (@(posedge clk_sys) disable iff (initRESET)
		core_reset_o == exp_core_reset)
		else begin
			reset_errors++;
			$display("error at %0t: core_reset_o, expected %0b", $time, exp_core_reset);
		end
	a_dma_we: assert property (@(posedge clk_sys) disable iff (initRESET)
		dma_we_o == exp_we)
		else begin
			dma_errors++;
			$display("error at %0t: dma_we_o, expected %0b", $time, exp_we);
		end
	a_dma_word: assert property (@(posedge clk_sys) disable iff (initRESET)
		exp_we |-> (dma_addr_o == exp_addr && dma_data_o == exp_data))
		else begin
			dma_errors++;
			$display("error at %0t: DMA write, expected %04h <= %02h", $time,
				exp_addr, exp_data);
		end

	////////////////////
	// Stimulus
	////////////////////

	function automatic pet_byte_t random_byte();
		logic [31:0] r;
		r = $urandom;
		return r[7:0];
	endfunction

	task automatic queue_write(input pet_addr_t a, input pet_byte_t d);
		nxt_we   = 1'b1;
		nxt_addr = a;
		nxt_data = d;
	endtask

	// One falling edge step of the host port, DMA result expected a cycle later
	task automatic drive_cycle(input logic dl, input pet_byte_t idx, input logic wr,
			input logic [24:0] addr, input pet_byte_t dout);
		logic is_prg;
		logic is_rom;
		is_prg = dl && (idx == `PET_IDX_PRG);
		is_rom = dl && (idx == `PET_IDX_ROM_A || idx == `PET_IDX_ROM_B);
		@(negedge clk_sys);
		exp_we           = nxt_we;
		exp_addr         = nxt_addr;
		exp_data         = nxt_data;
		nxt_we           = 1'b0;
		ioctl_download_i = dl;
		ioctl_index_i    = idx;
		ioctl_wr_i       = wr;
		ioctl_addr_i     = addr;
		ioctl_dout_i     = dout;
		if (is_prg && wr) begin
			if (addr == 25'd0) begin
				ref_load[7:0] = dout;
			end else if (addr == 25'd1) begin
				ref_load[15:8] = dout;
			end else if (ref_load < `PET_PRG_LIMIT) begin
				queue_write(ref_load, dout);
				ref_load = ref_load + 1'b1;
			end
		end
		if (is_rom && wr && addr >= `PET_ROM_BASE && addr < `PET_PRG_LIMIT)
			queue_write(addr[15:0] + `PET_ROM_OFFSET, dout);
		// Pointer low right after the drop, high two cycles later unless cancelled
		if (prg_open && !dl) begin
			queue_write(`PET_PTR_LO, ref_load[7:0]);
			hi_wait = 2;
		end else if (hi_wait > 0) begin
			hi_wait = dl ? 0 : hi_wait - 1;
			if (!dl && hi_wait == 0)
				queue_write(`PET_PTR_HI, ref_load[15:8]);
		end
		prg_open = is_prg;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) drive_cycle(1'b0, 8'h00, 1'b0, '0, '0);
	endtask

	task automatic wait_reset_release();
		while (core_reset_o)
			idle_cycles(1);
		idle_cycles(2);
	endtask

	// Two pulses flush the old rate, then the next periods use the new term
	task automatic check_speed(input cpu_speed_t spd);
		int pulses;
		rate_armed  = 1'b0;
		cpu_speed_i = spd;
		case (spd)
			SPD_NORMAL: exp_1m_gap = `PET_RATE_NORMAL + 1;
			SPD_FAST:   exp_1m_gap = `PET_RATE_FAST + 1;
			SPD_TURBO:  exp_1m_gap = `PET_RATE_TURBO + 1;
			default:    exp_1m_gap = `PET_RATE_TURBOP + 1;
		endcase
		pulses = 0;
		while (pulses < 2) begin
			idle_cycles(1);
			pulses += ce_1m_o;
		end
		idle_cycles(1);
		rate_armed = 1'b1;
		pulses     = 0;
		while (pulses < 3) begin
			idle_cycles(1);
			pulses += ce_1m_o;
		end
		rate_armed = 1'b0;
	endtask

	task automatic pulse_reset_req(input int n);
		reset_req_i = 1'b1;
		idle_cycles(n);
		reset_req_i = 1'b0;
		wait_reset_release();
	endtask

	task automatic load_prg(input pet_addr_t base, input int nbytes, input logic spaced,
			input logic abort);
		int i;
		drive_cycle(1'b1, `PET_IDX_PRG, 1'b1, 25'd0, base[7:0]);
		drive_cycle(1'b1, `PET_IDX_PRG, 1'b1, 25'd1, base[15:8]);
		for (i = 0; i < nbytes; i++) begin
			drive_cycle(1'b1, `PET_IDX_PRG, 1'b1, 25'(i + 2), random_byte());
			if (spaced)
				drive_cycle(1'b1, `PET_IDX_PRG, 1'b0, '0, '0);
		end
		idle_cycles(abort ? 1 : 6);
	endtask

	task automatic skip_download(input int nbytes);
		int i;
		for (i = 0; i < nbytes; i++)
			drive_cycle(1'b1, 8'h01, 1'b1, 25'(i), random_byte());
		idle_cycles(4);
	endtask

	task automatic load_rom(input pet_byte_t idx);
		foreach (ROM_OFFS[i]) begin
			drive_cycle(1'b1, idx, 1'b1, ROM_OFFS[i], random_byte());
			drive_cycle(1'b1, idx, 1'b0, '0, '0);
		end
		idle_cycles(4);
	endtask

	initial begin
		int s;
		clk_errors       = 0;
		reset_errors     = 0;
		dma_errors       = 0;
		initRESET        = 1'b1;
		reset_req_i      = 1'b0;
		cpu_speed_i      = SPD_NORMAL;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		{exp_we, nxt_we, prg_open, rate_armed} = '0;
		{exp_addr, nxt_addr, exp_data, nxt_data, ref_load} = '0;
		hi_wait    = 0;
		exp_1m_gap = 0;
		void'($urandom(RAND_SEED));
		repeat (RESET_CYCLES) @(negedge clk_sys);
		initRESET = 1'b0;
		wait_reset_release();
		for (s = 3; s >= 0; s--)
			check_speed(cpu_speed_t'(s));
		pulse_reset_req(3);
		load_prg(16'h0401, 8, 1'b0, 1'b0);
		load_prg(16'h1000, 5, 1'b1, 1'b0);
		// Crosses the top of RAM part way through
		load_prg(16'h7FF0, 20, 1'b0, 1'b0);
		load_prg(16'h2000, 4, 1'b0, 1'b1);
		skip_download(6);
		load_rom(`PET_IDX_ROM_A);
		load_rom(`PET_IDX_ROM_B);
		$display("clock errors %0d, reset errors %0d, dma errors %0d",
			clk_errors, reset_errors, dma_errors);
		if (clk_errors + reset_errors + dma_errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

/* project.f */
+incdir+include
design/pet_dl_pkg.sv
design/pet_clk_pkg.sv
design/pet_clk_enables.sv
design/pet_reset_seq.sv
design/pet_load_fsm.sv
design/pet_dma_writer.sv
design/pet_loader_top.sv
dv/tb_pet_loader.sv
